/* tl_pkg.sv */
package tl_pkg;

  parameter int unsigned addr_width = 16;
  parameter int unsigned data_width = 32;
  parameter int unsigned mask_width = data_width / 8;
  parameter int unsigned size_width = 2;
  parameter int unsigned dev_source_width = 3; // host ids sit in the low 2 bits

  typedef enum logic [2:0] {
    a_put_full_data = 3'd0,
    a_get           = 3'd4
  } a_opcode_e;

  typedef enum logic [2:0] {
    d_access_ack      = 3'd0,
    d_access_ack_data = 3'd1
  } d_opcode_e;

  typedef struct packed {
    a_opcode_e                   opcode;
    logic [size_width-1:0]       size;    // log2 of bytes
    logic [dev_source_width-1:0] source;
    logic [addr_width-1:0]       address; // word address
    logic [mask_width-1:0]       mask;
    logic [data_width-1:0]       data;
  } a_chan_t;

  typedef struct packed {
    d_opcode_e                   opcode;
    logic [size_width-1:0]       size;
    logic [dev_source_width-1:0] source;
    logic                        denied;
    logic [data_width-1:0]       data;
  } d_chan_t;

endpackage

/* tl_if.sv */
`timescale 1ns/1ps

interface tl_if;

  logic            a_valid;
  logic            a_ready;
  tl_pkg::a_chan_t a;

  logic            d_valid;
  logic            d_ready;
  tl_pkg::d_chan_t d;

  // requester side
  modport host (
    output a_valid,
    output a,
    input  a_ready,
    input  d_valid,
    input  d,
    output d_ready
  );

  // responder side
  modport device (
    input  a_valid,
    input  a,
    output a_ready,
    output d_valid,
    output d,
    input  d_ready
  );

endinterface

/* tl_source_shifter.sv */
`timescale 1ns/1ps

module tl_source_shifter #(
  parameter int unsigned                          host_source_width = 2,
  parameter logic [tl_pkg::dev_source_width-1:0] source_base       = '0,
  parameter logic [tl_pkg::dev_source_width-1:0] source_mask       = '1
) (
  tl_if.device host,
  tl_if.host   device
);

  logic [host_source_width-1:0] host_id;

  assign host_id = host.a.source[host_source_width-1:0]; // narrow id as issued

  // request channel
  assign device.a_valid = host.a_valid;
  assign host.a_ready   = device.a_ready;

  always_comb begin
    device.a        = host.a;
    device.a.source = source_base | tl_pkg::dev_source_width'(host_id); // into own region
  end

  // response channel
  assign host.d_valid   = device.d_valid;
  assign device.d_ready = host.d_ready;

  always_comb begin
    host.d        = device.d;
    host.d.source = device.d.source & source_mask; // back to host space
  end

endmodule

/* tl_fifo.sv */
`timescale 1ns/1ps

module tl_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign in_ready  = (count != 2'd2); // take a beat whenever a slot is free
  assign out_valid = (count != 2'd0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

/* tl_source_arbiter.sv */
`timescale 1ns/1ps

module tl_source_arbiter (
  input  logic clk_i,
  input  logic rst,
  tl_if.device host0,
  tl_if.device host1,
  tl_if.host   device
);

  localparam int unsigned region_bit = tl_pkg::dev_source_width - 1;

  logic ptr;        // host favored on a tie
  logic sel;        // host granted this cycle
  logic d_to_host1;

  // favored host wins if it asks, otherwise whoever asks
  always_comb begin
    if (ptr) begin
      sel = host1.a_valid | ~host0.a_valid;
    end else begin
      sel = host1.a_valid & ~host0.a_valid;
    end
  end

  assign device.a_valid = host0.a_valid | host1.a_valid;
  assign device.a       = sel ? host1.a : host0.a;
  assign host0.a_ready  = device.a_ready & ~sel;
  assign host1.a_ready  = device.a_ready & sel;

  // a stalled beat keeps its grant, so the payload stays stable
  always_ff @(posedge clk_i) begin
    if (rst) begin
      ptr <= 1'b0;
    end else if (device.a_valid) begin
      ptr <= device.a_ready ? ~sel : sel;
    end
  end

  // response routing by source region
  assign d_to_host1 = device.d.source[region_bit];

  assign host0.d_valid  = device.d_valid & ~d_to_host1;
  assign host1.d_valid  = device.d_valid & d_to_host1;
  assign host0.d        = device.d;
  assign host1.d        = device.d;
  assign device.d_ready = d_to_host1 ? host1.d_ready : host0.d_ready;

endmodule

/* tl_ram_device.sv */
`timescale 1ns/1ps

module tl_ram_device #(
  parameter int unsigned ram_words = 256
) (
  input  logic            clk_i,
  input  logic            rst,
  input  logic            a_valid,
  output logic            a_ready,
  input  tl_pkg::a_chan_t a,
  output logic            d_valid,
  input  logic            d_ready,
  output tl_pkg::d_chan_t d
);

  localparam int unsigned index_width = $clog2(ram_words);

  logic [tl_pkg::data_width-1:0] mem [ram_words];
  logic [index_width-1:0]        index;
  logic                          accept;
  logic                          in_range;
  logic                          is_get;
  logic                          is_put;
  logic                          write_en;

  assign a_ready  = ~d_valid | d_ready; // response slot empty or draining
  assign accept   = a_valid & a_ready;
  assign index    = a.address[index_width-1:0];
  assign in_range = (32'(a.address) < ram_words);
  assign is_get   = (a.opcode == tl_pkg::a_get);
  assign is_put   = (a.opcode == tl_pkg::a_put_full_data);
  assign write_en = accept & is_put & in_range;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      d_valid <= 1'b0;
    end else if (accept) begin
      d_valid <= 1'b1;
    end else if (d_ready) begin
      d_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      d.opcode <= is_get ? tl_pkg::d_access_ack_data : tl_pkg::d_access_ack;
      d.size   <= a.size;
      d.source <= a.source; // echoed for routing back
      d.denied <= ~(in_range & (is_get | is_put));
      d.data   <= (is_get & in_range) ? mem[index] : '0;
    end
  end

  // byte lanes written per mask
  always_ff @(posedge clk_i) begin
    if (write_en) begin
      for (int b = 0; b < tl_pkg::mask_width; b++) begin
        if (a.mask[b]) mem[index][8*b +: 8] <= a.data[8*b +: 8];
      end
    end
  end

endmodule

/* tl_subsystem_top.sv */
`timescale 1ns/1ps

module tl_subsystem_top #(
  parameter int unsigned host_source_width = 2,
  parameter int unsigned ram_words         = 256,
  parameter logic [tl_pkg::dev_source_width-1:0] host0_source_base = 3'd0,
  parameter logic [tl_pkg::dev_source_width-1:0] host1_source_base = 3'd4,
  parameter logic [tl_pkg::dev_source_width-1:0] source_mask       = 3'd3
) (
  input  logic                          clk_i,
  input  logic                          rst,

  input  logic                          h0_a_valid,
  output logic                          h0_a_ready,
  input  logic [2:0]                    h0_a_opcode,
  input  logic [tl_pkg::addr_width-1:0] h0_a_address,
  input  logic [tl_pkg::mask_width-1:0] h0_a_mask,
  input  logic [tl_pkg::data_width-1:0] h0_a_data,
  input  logic [host_source_width-1:0]  h0_a_source,
  output logic                          h0_d_valid,
  input  logic                          h0_d_ready,
  output logic [2:0]                    h0_d_opcode,
  output logic [host_source_width-1:0]  h0_d_source,
  output logic [tl_pkg::data_width-1:0] h0_d_data,
  output logic                          h0_d_denied,

  input  logic                          h1_a_valid,
  output logic                          h1_a_ready,
  input  logic [2:0]                    h1_a_opcode,
  input  logic [tl_pkg::addr_width-1:0] h1_a_address,
  input  logic [tl_pkg::mask_width-1:0] h1_a_mask,
  input  logic [tl_pkg::data_width-1:0] h1_a_data,
  input  logic [host_source_width-1:0]  h1_a_source,
  output logic                          h1_d_valid,
  input  logic                          h1_d_ready,
  output logic [2:0]                    h1_d_opcode,
  output logic [host_source_width-1:0]  h1_d_source,
  output logic [tl_pkg::data_width-1:0] h1_d_data,
  output logic                          h1_d_denied
);

  tl_if h0_if ();  // host 0 port side
  tl_if h1_if ();
  tl_if s0_if ();  // shifted, into arbiter
  tl_if s1_if ();
  tl_if arb_if (); // arbiter to FIFOs
  tl_if ram_if (); // FIFOs to RAM

  // host 0 packing, single word beats only
  assign h0_if.a_valid = h0_a_valid;
  assign h0_if.a = '{
    opcode:  tl_pkg::a_opcode_e'(h0_a_opcode),
    size:    2'd2,
    source:  tl_pkg::dev_source_width'(h0_a_source),
    address: h0_a_address,
    mask:    h0_a_mask,
    data:    h0_a_data
  };
  assign h0_if.d_ready = h0_d_ready;
  assign h0_a_ready    = h0_if.a_ready;
  assign h0_d_valid    = h0_if.d_valid;
  assign h0_d_opcode   = h0_if.d.opcode;
  assign h0_d_source   = h0_if.d.source[host_source_width-1:0];
  assign h0_d_data     = h0_if.d.data;
  assign h0_d_denied   = h0_if.d.denied;

  assign h1_if.a_valid = h1_a_valid;
  assign h1_if.a = '{
    opcode:  tl_pkg::a_opcode_e'(h1_a_opcode),
    size:    2'd2,
    source:  tl_pkg::dev_source_width'(h1_a_source),
    address: h1_a_address,
    mask:    h1_a_mask,
    data:    h1_a_data
  };
  assign h1_if.d_ready = h1_d_ready;
  assign h1_a_ready    = h1_if.a_ready;
  assign h1_d_valid    = h1_if.d_valid;
  assign h1_d_opcode   = h1_if.d.opcode;
  assign h1_d_source   = h1_if.d.source[host_source_width-1:0];
  assign h1_d_data     = h1_if.d.data;
  assign h1_d_denied   = h1_if.d.denied;

  tl_source_shifter #(
    .host_source_width (host_source_width),
    .source_base       (host0_source_base),
    .source_mask       (source_mask)
  ) u_shift0 (
    .host   (h0_if),
    .device (s0_if)
  );

  tl_source_shifter #(
    .host_source_width (host_source_width),
    .source_base       (host1_source_base),
    .source_mask       (source_mask)
  ) u_shift1 (
    .host   (h1_if),
    .device (s1_if)
  );

  tl_source_arbiter u_arbiter (
    .clk_i  (clk_i),
    .rst    (rst),
    .host0  (s0_if),
    .host1  (s1_if),
    .device (arb_if)
  );

  tl_fifo #(
    .payload_t (tl_pkg::a_chan_t)
  ) u_req_fifo (
    .clk_i     (clk_i),
    .rst       (rst),
    .in_valid  (arb_if.a_valid),
    .in_ready  (arb_if.a_ready),
    .in_data   (arb_if.a),
    .out_valid (ram_if.a_valid),
    .out_ready (ram_if.a_ready),
    .out_data  (ram_if.a)
  );

  tl_ram_device #(
    .ram_words (ram_words)
  ) u_ram (
    .clk_i   (clk_i),
    .rst     (rst),
    .a_valid (ram_if.a_valid),
    .a_ready (ram_if.a_ready),
    .a       (ram_if.a),
    .d_valid (ram_if.d_valid),
    .d_ready (ram_if.d_ready),
    .d       (ram_if.d)
  );

  tl_fifo #(
    .payload_t (tl_pkg::d_chan_t)
  ) u_rsp_fifo (
    .clk_i     (clk_i),
    .rst       (rst),
    .in_valid  (ram_if.d_valid),
    .in_ready  (ram_if.d_ready),
    .in_data   (ram_if.d),
    .out_valid (arb_if.d_valid),
    .out_ready (arb_if.d_ready),
    .out_data  (arb_if.d)
  );

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  localparam int unsigned max_cases       = 56;
  localparam int unsigned num_fields      = 9;
  localparam int unsigned mem_words       = 512; // count word plus max_cases lines
  localparam int unsigned max_outstanding = 4;
  localparam int unsigned cycles_per_case = 200;
  localparam int unsigned reset_cycles    = 2;
  localparam int unsigned drain_cycles    = 10;
  localparam int unsigned ready_percent   = 60;
  localparam int unsigned rand_seed       = 56246;
  localparam logic [31:0] sync_host       = 32'hf; // host field of a barrier line

  // field positions within one case line
  localparam int f_host = 0;
  localparam int f_opcode = 1;
  localparam int f_address = 2;
  localparam int f_mask = 3;
  localparam int f_data = 4;
  localparam int f_source = 5;
  localparam int f_exp_opcode = 6;
  localparam int f_exp_denied = 7;
  localparam int f_exp_data = 8;

  typedef struct packed {
    logic [1:0]  source;
    logic [2:0]  opcode;
    logic        denied;
    logic [31:0] data;
  } expect_t;

  logic clk_i;
  logic rst;

  logic        h0_a_valid, h0_a_ready, h0_d_valid, h0_d_ready, h0_d_denied;
  logic [2:0]  h0_a_opcode, h0_d_opcode;
  logic [15:0] h0_a_address;
  logic [3:0]  h0_a_mask;
  logic [31:0] h0_a_data, h0_d_data;
  logic [1:0]  h0_a_source, h0_d_source;

  logic        h1_a_valid, h1_a_ready, h1_d_valid, h1_d_ready, h1_d_denied;
  logic [2:0]  h1_a_opcode, h1_d_opcode;
  logic [15:0] h1_a_address;
  logic [3:0]  h1_a_mask;
  logic [31:0] h1_a_data, h1_d_data;
  logic [1:0]  h1_a_source, h1_d_source;

  logic [31:0] case_mem [mem_words];
  int          case_count = 0;
  expect_t     exp_q0 [$];
  expect_t     exp_q1 [$];
  logic        done0 = 1'b0;
  logic        done1 = 1'b0;
  int          barrier0 = -1; // last barrier line each driver reached
  int          barrier1 = -1;

  tl_subsystem_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk_i);
    #1 rst = 1'b0;
  end

  function automatic logic [31:0] case_field(input int c, input int f);
    return case_mem[9'(1 + c * num_fields + f)];
  endfunction

  function automatic expect_t expected_for(input int c);
    expect_t e;
    e.source = 2'(case_field(c, f_source)); // host sees its own id again
    e.opcode = 3'(case_field(c, f_exp_opcode));
    e.denied = (case_field(c, f_exp_denied) != 0);
    e.data   = case_field(c, f_exp_data);
    return e;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Error at %0d ns: %s = %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_response(input int host, input logic [2:0] opcode,
                                input logic [1:0] source, input logic denied,
                                input logic [31:0] data);
    expect_t want;
    string   pre;
    pre = $sformatf("h%0d_d_", host);
    if (host == 0 && exp_q0.size() > 0) want = exp_q0.pop_front();
    else if (host == 1 && exp_q1.size() > 0) want = exp_q1.pop_front();
    else abort_run($sformatf("Host %0d got a response it never asked for", host));
    check_value({pre, "opcode"}, 32'(opcode), 32'(want.opcode));
    check_value({pre, "source"}, 32'(source), 32'(want.source));
    check_value({pre, "denied"}, 32'(denied), 32'(want.denied));
    check_value({pre, "data"}, data, want.data);
  endtask

  task automatic wait_reset_release();
    do begin
      @(posedge clk_i);
    end while (rst);
    #1;
  endtask

  // earlier cases of both hosts finish before either goes on
  task automatic wait_barrier(input int c);
    while (barrier0 < c || barrier1 < c || exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin : host0_driver
    logic accepted;
    h0_a_valid   = 1'b0;
    h0_a_opcode  = '0;
    h0_a_address = '0;
    h0_a_mask    = '0;
    h0_a_data    = '0;
    h0_a_source  = '0;
    wait_reset_release();
    for (int c = 0; c < case_count; c++) begin
      if (case_field(c, f_host) == sync_host) begin
        barrier0 = c;
        wait_barrier(c);
      end else if (case_field(c, f_host) == 0) begin
        while (exp_q0.size() >= max_outstanding) begin // keeps source ids unique
          @(posedge clk_i);
          #1;
        end
        h0_a_valid   = 1'b1;
        h0_a_opcode  = 3'(case_field(c, f_opcode));
        h0_a_address = 16'(case_field(c, f_address));
        h0_a_mask    = 4'(case_field(c, f_mask));
        h0_a_data    = case_field(c, f_data);
        h0_a_source  = 2'(case_field(c, f_source));
        do begin
          @(negedge clk_i);
          accepted = h0_a_ready; // beat moves on the coming edge
          if (accepted) exp_q0.push_back(expected_for(c));
          @(posedge clk_i);
          #1;
        end while (!accepted);
        h0_a_valid = 1'b0;
      end
    end
    done0 = 1'b1;
  end

  initial begin : host1_driver
    logic accepted;
    h1_a_valid   = 1'b0;
    h1_a_opcode  = '0;
    h1_a_address = '0;
    h1_a_mask    = '0;
    h1_a_data    = '0;
    h1_a_source  = '0;
    wait_reset_release();
    for (int c = 0; c < case_count; c++) begin
      if (case_field(c, f_host) == sync_host) begin
        barrier1 = c;
        wait_barrier(c);
      end else if (case_field(c, f_host) == 1) begin
        while (exp_q1.size() >= max_outstanding) begin
          @(posedge clk_i);
          #1;
        end
        h1_a_valid   = 1'b1;
        h1_a_opcode  = 3'(case_field(c, f_opcode));
        h1_a_address = 16'(case_field(c, f_address));
        h1_a_mask    = 4'(case_field(c, f_mask));
        h1_a_data    = case_field(c, f_data);
        h1_a_source  = 2'(case_field(c, f_source));
        do begin
          @(negedge clk_i);
          accepted = h1_a_ready;
          if (accepted) exp_q1.push_back(expected_for(c));
          @(posedge clk_i);
          #1;
        end while (!accepted);
        h1_a_valid = 1'b0;
      end
    end
    done1 = 1'b1;
  end

  initial begin : back_pressure
    h0_d_ready = 1'b0;
    h1_d_ready = 1'b0;
    void'($urandom(rand_seed));
    forever begin
      @(posedge clk_i);
      #1;
      h0_d_ready = (($urandom % 100) < ready_percent);
      h1_d_ready = (($urandom % 100) < ready_percent);
    end
  end

  // D beats sampled mid-cycle, where valid and ready are settled
  initial begin : response_monitor
    forever begin
      @(negedge clk_i);
      if (!rst) begin
        if (h0_d_valid && h0_d_ready) begin
          check_response(0, h0_d_opcode, h0_d_source, h0_d_denied, h0_d_data);
        end
        if (h1_d_valid && h1_d_ready) begin
          check_response(1, h1_d_opcode, h1_d_source, h1_d_denied, h1_d_data);
        end
      end
    end
  end

  initial begin : watchdog
    @(posedge clk_i);
    repeat (reset_cycles + cycles_per_case * case_count) @(posedge clk_i);
    abort_run($sformatf("Timeout: run did not finish, %0d host 0 and %0d host 1 responses missing",
                        exp_q0.size(), exp_q1.size()));
  end

  initial begin : main_control
    $readmemh("tl_cases.txt", case_mem);
    case_count = int'(case_mem[0]);
    if (case_count == 0 || case_count > max_cases) begin
      abort_run("Case file tl_cases.txt is missing or holds a bad case count");
    end else begin
      do begin
        @(posedge clk_i);
      end while (!(done0 && done1 && exp_q0.size() == 0 && exp_q1.size() == 0));
      repeat (drain_cycles) @(posedge clk_i); // a stray or repeated beat still gets caught
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* tl_cases.txt */
// first value is the case count, then one case per line, all fields hex
// host opcode address mask data source exp_opcode exp_denied exp_data (host f waits for both)
1f
0 0 0010 f 11223344 0 0 0 00000000
0 4 0010 f 00000000 1 1 0 11223344
0 0 0010 3 0000aabb 2 0 0 00000000
0 4 0010 f 00000000 3 1 0 1122aabb
1 0 0020 f cafef00d 0 0 0 00000000
1 0 0021 f 00000000 1 0 0 00000000
1 0 0021 c 12345678 2 0 0 00000000
1 4 0021 f 00000000 3 1 0 12340000
0 4 0100 f 00000000 0 1 1 00000000
0 0 0200 f deadbeef 1 0 1 00000000
0 2 0010 f 55555555 2 0 1 00000000
0 4 0010 f 00000000 3 1 0 1122aabb
1 0 00ff f 0f0f0f0f 0 0 0 00000000
1 6 0020 f 77777777 1 0 1 00000000
1 4 ffff f 00000000 2 1 1 00000000
1 4 0020 f 00000000 3 1 0 cafef00d
f 0 0000 0 00000000 0 0 0 00000000
0 4 0020 f 00000000 0 1 0 cafef00d
1 4 0010 f 00000000 0 1 0 1122aabb
0 4 0021 f 00000000 1 1 0 12340000
1 4 00ff f 00000000 1 1 0 0f0f0f0f
0 0 0040 f a0a0a0a0 2 0 0 00000000
1 0 0050 f b0b0b0b0 2 0 0 00000000
0 0 0041 f a1a1a1a1 3 0 0 00000000
1 0 0051 f b1b1b1b1 3 0 0 00000000
0 4 0040 f 00000000 0 1 0 a0a0a0a0
1 4 0050 f 00000000 0 1 0 b0b0b0b0
0 4 0041 f 00000000 1 1 0 a1a1a1a1
1 4 0051 f 00000000 1 1 0 b1b1b1b1
0 0 0040 8 5a000000 2 0 0 00000000
0 4 0040 f 00000000 3 1 0 5aa0a0a0

/* vlog.f */
tl_pkg.sv
tl_if.sv
tl_source_shifter.sv
tl_fifo.sv
tl_source_arbiter.sv
tl_ram_device.sv
tl_subsystem_top.sv
tb_top.sv

/* Makefile */
SRCS := $(wildcard *.sv)

obj_dir/Vtb_top: vlog.f $(SRCS)
	verilator --binary --timing --top-module tb_top -f vlog.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top

clean:
	rm -rf obj_dir

.PHONY: run clean
